//--- Bender.yml
package:
  name: id_stage

sources:
  - rv_isa_pkg.sv
  - id_bus_pkg.sv
  - id_stage_reg.sv
  - id_decoder.sv
  - id_operand_read.sv
  - id_branch_unit.sv
  - id_stage.sv
  - target: test
    files:
      - tb_id_stage.sv

//--- id_branch_unit.sv
// target is the fall-through pc when nothing redirects; funct3 010/011 never taken
`timescale 1ns/10ps

module id_branch_unit (
  input  logic                        i_ds_valid,
  input  logic                        i_load_stall,
  input  id_bus_pkg::br_kind_e        i_br_kind,
  input  logic [2:0]                  i_br_func,
  input  logic [rv_isa_pkg::XLEN-1:0] i_pc,
  input  logic [rv_isa_pkg::XLEN-1:0] i_imm,
  input  logic [rv_isa_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] i_rs2_data,
  output logic                        o_br_taken,
  output logic                        o_br_stall,
  output logic [rv_isa_pkg::XLEN-1:0] o_br_target
);

  logic                        cond_true;
  logic                        redirect;
  logic [rv_isa_pkg::XLEN-1:0] pc_rel;
  logic [rv_isa_pkg::XLEN-1:0] reg_rel;

  always_comb begin
    case (i_br_func)
      rv_isa_pkg::F3_BEQ:  cond_true = (i_rs1_data == i_rs2_data);
      rv_isa_pkg::F3_BNE:  cond_true = (i_rs1_data != i_rs2_data);
      rv_isa_pkg::F3_BLT:  cond_true = ($signed(i_rs1_data) < $signed(i_rs2_data));
      rv_isa_pkg::F3_BGE:  cond_true = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      rv_isa_pkg::F3_BLTU: cond_true = (i_rs1_data < i_rs2_data);
      rv_isa_pkg::F3_BGEU: cond_true = (i_rs1_data >= i_rs2_data);
      default:             cond_true = 1'b0;
    endcase
  end

  assign redirect = (i_br_kind == id_bus_pkg::JAL) || (i_br_kind == id_bus_pkg::JALR) ||
                    ((i_br_kind == id_bus_pkg::COND) && cond_true);

  assign pc_rel  = i_pc + i_imm;
  assign reg_rel = i_rs1_data + i_imm;

  assign o_br_target = !redirect                        ? i_pc + rv_isa_pkg::PC_STEP :
                       (i_br_kind == id_bus_pkg::JALR) ? {reg_rel[rv_isa_pkg::XLEN-1:1], 1'b0} :
                                                         pc_rel;

  // operands may be stale during a stall, so fetch is told to wait instead
  assign o_br_taken = i_ds_valid && !i_load_stall && redirect;
  assign o_br_stall = i_ds_valid && i_load_stall && (i_br_kind != id_bus_pkg::NONE);

endmodule

//--- id_bus_pkg.sv
// decode results for execute and fetch; execute owns the alu, this only names its ops
package id_bus_pkg;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10  // lui
  } alu_op_e;

  typedef enum logic [1:0] {NONE, COND, JAL, JALR} br_kind_e;

  // operand A select
  typedef enum logic {RS1, PC} src_a_e;

  // operand B select
  typedef enum logic {RS2, IMM} src_b_e;

endpackage

//--- id_decoder.sv
// jumps send src_a=PC with src_b=RS2, a pair no other op uses; execute writes pc+PC_STEP
`timescale 1ns/10ps

module id_decoder (
  input  logic [rv_isa_pkg::ILEN-1:0]       i_inst,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rs1,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rs2,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rd,
  output logic [rv_isa_pkg::XLEN-1:0]       o_imm,
  output id_bus_pkg::alu_op_e               o_alu_op,
  output id_bus_pkg::src_a_e                o_src_a,
  output id_bus_pkg::src_b_e                o_src_b,
  output id_bus_pkg::br_kind_e              o_br_kind,
  output logic [2:0]                        o_br_func,
  output logic                              o_gpr_wen,
  output logic                              o_mem_ren,
  output logic                              o_mem_wen,
  output logic [2:0]                        o_mem_op,
  output logic                              o_invalid
);

  localparam int XLEN = rv_isa_pkg::XLEN;

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_s;
  logic [XLEN-1:0]     imm_b;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     imm_j;

  // alt picks sub/sra
  function automatic id_bus_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? id_bus_pkg::SUB : id_bus_pkg::ADD;
      3'b001:  alu_sel = id_bus_pkg::SLL;
      3'b010:  alu_sel = id_bus_pkg::SLT;
      3'b011:  alu_sel = id_bus_pkg::SLTU;
      3'b100:  alu_sel = id_bus_pkg::XOR;
      3'b101:  alu_sel = alt ? id_bus_pkg::SRA : id_bus_pkg::SRL;
      3'b110:  alu_sel = id_bus_pkg::OR;
      default: alu_sel = id_bus_pkg::AND;
    endcase
  endfunction

  assign opcode    = rv_isa_pkg::opcode_e'(i_inst[6:0]);
  assign funct3    = i_inst[14:12];
  assign o_rd      = i_inst[11:7];
  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_br_func = funct3;

  // sign is inst[31] in every format
  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    o_imm     = '0;
    o_alu_op  = id_bus_pkg::ADD;
    o_src_a   = id_bus_pkg::RS1;
    o_src_b   = id_bus_pkg::IMM;
    o_br_kind = id_bus_pkg::NONE;
    o_gpr_wen = 1'b0;
    o_mem_ren = 1'b0;
    o_mem_wen = 1'b0;
    o_mem_op  = 3'b000;
    o_invalid = 1'b0;
    case (opcode)
      rv_isa_pkg::OP: begin
        o_src_b   = id_bus_pkg::RS2;
        o_alu_op  = alu_sel(funct3, i_inst[30]);
        o_gpr_wen = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        o_imm     = imm_i;
        o_alu_op  = alu_sel(funct3, i_inst[30] && (funct3 == 3'b101)); // srai only
        o_gpr_wen = 1'b1;
      end
      rv_isa_pkg::LOAD: begin
        o_imm     = imm_i;
        o_mem_ren = 1'b1;
        o_mem_op  = funct3;
        o_gpr_wen = 1'b1;
      end
      rv_isa_pkg::STORE: begin
        o_imm     = imm_s;
        o_mem_wen = 1'b1;
        o_mem_op  = funct3;
      end
      rv_isa_pkg::BRANCH: begin
        o_imm     = imm_b;
        o_src_b   = id_bus_pkg::RS2;
        o_br_kind = id_bus_pkg::COND;
      end
      rv_isa_pkg::JAL: begin
        o_imm     = imm_j;
        o_src_a   = id_bus_pkg::PC;
        o_src_b   = id_bus_pkg::RS2; // link marker
        o_br_kind = id_bus_pkg::JAL;
        o_gpr_wen = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        o_imm     = imm_i;
        o_src_a   = id_bus_pkg::PC;
        o_src_b   = id_bus_pkg::RS2; // link marker
        o_br_kind = id_bus_pkg::JALR;
        o_gpr_wen = 1'b1;
      end
      rv_isa_pkg::LUI: begin
        o_imm     = imm_u;
        o_alu_op  = id_bus_pkg::PASS_B;
        o_gpr_wen = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        o_imm     = imm_u;
        o_src_a   = id_bus_pkg::PC;
        o_gpr_wen = 1'b1;
      end
      default: o_invalid = 1'b1; // no enables, no branch
    endcase
  end

  invalid_no_write: assert final (!(o_invalid && (o_gpr_wen || o_mem_wen)));

endmodule

//--- id_operand_read.sv
// no reset on the register file; entries read as x until written, x0 always reads zero
`timescale 1ns/10ps

module id_operand_read (
  input  logic                              i_clk,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs1,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs2,
  input  logic                              i_ws_rf_wen,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ws_rf_waddr,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_ws_rf_wdata,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_es_byp_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_es_byp_data,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ms_byp_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_ms_byp_data,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ws_byp_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_ws_byp_data,
  output logic [rv_isa_pkg::XLEN-1:0]       o_rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       o_rs2_data
);

  localparam int AW = rv_isa_pkg::REG_ADDR_W;
  localparam int DW = rv_isa_pkg::XLEN;

  logic [DW-1:0] rf [rv_isa_pkg::NUM_GPR];

  always_ff @(posedge i_clk) begin
    if (i_ws_rf_wen && (i_ws_rf_waddr != '0)) begin
      rf[i_ws_rf_waddr] <= i_ws_rf_wdata;
    end
  end

  // youngest producer first; index 0 never forwards
  function automatic logic [DW-1:0] read_port(
    input logic [AW-1:0] rs,
    input logic [DW-1:0] rf_data,
    input logic [AW-1:0] es_rd,
    input logic [DW-1:0] es_data,
    input logic [AW-1:0] ms_rd,
    input logic [DW-1:0] ms_data,
    input logic [AW-1:0] ws_rd,
    input logic [DW-1:0] ws_data
  );
    if (rs == '0)                           read_port = '0;
    else if ((es_rd != '0) && (es_rd == rs)) read_port = es_data;
    else if ((ms_rd != '0) && (ms_rd == rs)) read_port = ms_data;
    else if ((ws_rd != '0) && (ws_rd == rs)) read_port = ws_data;
    else                                    read_port = rf_data;
  endfunction

  assign o_rs1_data = read_port(i_rs1, rf[i_rs1], i_es_byp_rd, i_es_byp_data,
                                i_ms_byp_rd, i_ms_byp_data, i_ws_byp_rd, i_ws_byp_data);
  assign o_rs2_data = read_port(i_rs2, rf[i_rs2], i_es_byp_rd, i_es_byp_data,
                                i_ms_byp_rd, i_ms_byp_data, i_ws_byp_rd, i_ws_byp_data);

  x0_reads_zero: assert property (@(posedge i_clk)
    ((i_rs1 !== '0) || (o_rs1_data === '0)) && ((i_rs2 !== '0) || (o_rs2_data === '0)));

endmodule

//--- id_stage.sv
// single register stage; execute gets decode results combinationally from the held instruction
`timescale 1ns/10ps

module id_stage (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_fs_to_ds_valid,
  input  logic [rv_isa_pkg::ILEN-1:0]       i_fs_inst,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_fs_pc,
  input  logic                              i_es_allowin,
  input  logic                              i_es_load,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_es_byp_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_es_byp_data,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ms_byp_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_ms_byp_data,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ws_byp_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_ws_byp_data,
  input  logic                              i_ws_rf_wen,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ws_rf_waddr,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_ws_rf_wdata,
  output logic                              o_ds_allowin,
  output logic                              o_ds_to_es_valid,
  output logic [rv_isa_pkg::XLEN-1:0]       o_es_pc,
  output logic [rv_isa_pkg::XLEN-1:0]       o_es_rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       o_es_rs2_data,
  output logic [rv_isa_pkg::XLEN-1:0]       o_es_imm,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_es_rd,
  output id_bus_pkg::alu_op_e               o_es_alu_op,
  output id_bus_pkg::src_a_e                o_es_src_a,
  output id_bus_pkg::src_b_e                o_es_src_b,
  output logic                              o_es_gpr_wen,
  output logic                              o_es_mem_ren,
  output logic                              o_es_mem_wen,
  output logic [2:0]                        o_es_mem_op,
  output logic                              o_es_invalid,
  output logic                              o_br_taken,
  output logic                              o_br_stall,
  output logic [rv_isa_pkg::XLEN-1:0]       o_br_target
);

  logic                              ds_valid;
  logic                              load_stall;
  logic [rv_isa_pkg::ILEN-1:0]       ds_inst;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
  id_bus_pkg::br_kind_e              br_kind;
  logic [2:0]                        br_func;

  id_stage_reg u_stage_reg (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_es_load        (i_es_load),
    .i_es_byp_rd      (i_es_byp_rd),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_valid       (ds_valid),
    .o_load_stall     (load_stall),
    .o_inst           (ds_inst),
    .o_pc             (o_es_pc)
  );

  id_decoder u_decoder (
    .i_inst    (ds_inst),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_rd      (o_es_rd),
    .o_imm     (o_es_imm),
    .o_alu_op  (o_es_alu_op),
    .o_src_a   (o_es_src_a),
    .o_src_b   (o_es_src_b),
    .o_br_kind (br_kind),
    .o_br_func (br_func),
    .o_gpr_wen (o_es_gpr_wen),
    .o_mem_ren (o_es_mem_ren),
    .o_mem_wen (o_es_mem_wen),
    .o_mem_op  (o_es_mem_op),
    .o_invalid (o_es_invalid)
  );

  id_operand_read u_operand_read (
    .i_clk         (i_clk),
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_ws_rf_wen   (i_ws_rf_wen),
    .i_ws_rf_waddr (i_ws_rf_waddr),
    .i_ws_rf_wdata (i_ws_rf_wdata),
    .i_es_byp_rd   (i_es_byp_rd),
    .i_es_byp_data (i_es_byp_data),
    .i_ms_byp_rd   (i_ms_byp_rd),
    .i_ms_byp_data (i_ms_byp_data),
    .i_ws_byp_rd   (i_ws_byp_rd),
    .i_ws_byp_data (i_ws_byp_data),
    .o_rs1_data    (o_es_rs1_data),
    .o_rs2_data    (o_es_rs2_data)
  );

  // compares on forwarded operands, same values execute sees
  id_branch_unit u_branch_unit (
    .i_ds_valid   (ds_valid),
    .i_load_stall (load_stall),
    .i_br_kind    (br_kind),
    .i_br_func    (br_func),
    .i_pc         (o_es_pc),
    .i_imm        (o_es_imm),
    .i_rs1_data   (o_es_rs1_data),
    .i_rs2_data   (o_es_rs2_data),
    .o_br_taken   (o_br_taken),
    .o_br_stall   (o_br_stall),
    .o_br_target  (o_br_target)
  );

endmodule

//--- id_stage_reg.sv
// stall uses raw rs1/rs2 fields, so an unused rs2 field can also stall behind a load
`timescale 1ns/10ps

module id_stage_reg (
  input  logic                                i_clk,
  input  logic                                i_reset,
  input  logic                                i_fs_to_ds_valid,
  input  logic [rv_isa_pkg::ILEN-1:0]         i_fs_inst,
  input  logic [rv_isa_pkg::XLEN-1:0]         i_fs_pc,
  input  logic                                i_es_allowin,
  input  logic                                i_es_load,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   i_es_byp_rd,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   i_rs1,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   i_rs2,
  output logic                                o_ds_allowin,
  output logic                                o_ds_to_es_valid,
  output logic                                o_ds_valid,
  output logic                                o_load_stall,
  output logic [rv_isa_pkg::ILEN-1:0]         o_inst,
  output logic [rv_isa_pkg::XLEN-1:0]         o_pc
);

  logic                        ds_valid;
  logic                        ready_go;
  logic [rv_isa_pkg::ILEN-1:0] inst_r;
  logic [rv_isa_pkg::XLEN-1:0] pc_r;

  // load still in execute, its data only comes back from mem
  assign o_load_stall = i_es_load && (i_es_byp_rd != '0) &&
                        ((i_es_byp_rd == i_rs1) || (i_es_byp_rd == i_rs2));

  assign ready_go         = ~o_load_stall;
  assign o_ds_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ready_go;
  assign o_ds_valid       = ds_valid;
  assign o_inst           = inst_r;
  assign o_pc             = pc_r;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid; // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      inst_r <= i_fs_inst;
      pc_r   <= i_fs_pc;
    end
  end

  no_issue_in_stall: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_ds_to_es_valid && o_load_stall));

  // full and not leaving, so the held instruction must sit still
  hold_when_blocked: assert property (@(posedge i_clk) disable iff (i_reset)
    (ds_valid && !(o_ds_to_es_valid && i_es_allowin)) |=>
      (ds_valid && $stable(inst_r) && $stable(pc_r)));

endmodule

//--- rv_isa_pkg.sv
// rv64i base encodings only; no compressed, word-width, csr or system opcodes
package rv_isa_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_GPR    = 32;

  localparam logic [XLEN-1:0] PC_STEP = XLEN'(4); // no compressed instructions

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

//--- src.f
rv_isa_pkg.sv
id_bus_pkg.sv
id_stage_reg.sv
id_decoder.sv
id_operand_read.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

//--- tb_id_stage.sv
// one instruction in flight at a time; inputs move 2 ns after the edge, checks sit mid-cycle
`timescale 1ns/10ps

module tb_id_stage;

  localparam int XLEN       = rv_isa_pkg::XLEN;
  localparam int ILEN       = rv_isa_pkg::ILEN;
  localparam int AW         = rv_isa_pkg::REG_ADDR_W;
  localparam int WAIT_LIMIT = 20;

  logic                 clk;
  logic                 reset;
  logic                 fs_valid;
  logic [ILEN-1:0]      fs_inst;
  logic [XLEN-1:0]      fs_pc;
  logic                 es_allowin;
  logic                 es_load;
  logic [AW-1:0]        es_byp_rd;
  logic [XLEN-1:0]      es_byp_data;
  logic [AW-1:0]        ms_byp_rd;
  logic [XLEN-1:0]      ms_byp_data;
  logic [AW-1:0]        ws_byp_rd;
  logic [XLEN-1:0]      ws_byp_data;
  logic                 ws_rf_wen;
  logic [AW-1:0]        ws_rf_waddr;
  logic [XLEN-1:0]      ws_rf_wdata;
  logic                 ds_allowin;
  logic                 ds_to_es_valid;
  logic [XLEN-1:0]      es_pc;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic [XLEN-1:0]      es_imm;
  logic [AW-1:0]        es_rd;
  id_bus_pkg::alu_op_e  es_alu_op;
  id_bus_pkg::src_a_e   es_src_a;
  id_bus_pkg::src_b_e   es_src_b;
  logic                 gpr_wen;
  logic                 mem_ren;
  logic                 mem_wen;
  logic [2:0]           mem_op;
  logic                 es_invalid;
  logic                 br_taken;
  logic                 br_stall;
  logic [XLEN-1:0]      br_target;

  integer          seed = 67270;
  int              test_errors = 0;
  int              pass_tests = 0;
  int              fail_tests = 0;
  int              leave_count = 0;
  int              leaves_before;
  logic [XLEN-1:0] shadow [32];
  logic [AW-1:0]   ra;
  logic [AW-1:0]   rb;
  logic [AW-1:0]   rd;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_b;
  logic [XLEN-1:0] da;
  logic [XLEN-1:0] db;
  logic [XLEN-1:0] dc;
  logic [12:0]     boff;
  logic [20:0]     joff;
  logic [11:0]     imm12;
  logic [19:0]     imm20;
  logic            exp_taken;
  logic [2:0]      br_funcs [6];

  id_stage u_dut (
    .i_clk (clk), .i_reset (reset),
    .i_fs_to_ds_valid (fs_valid), .i_fs_inst (fs_inst), .i_fs_pc (fs_pc),
    .i_es_allowin (es_allowin), .i_es_load (es_load),
    .i_es_byp_rd (es_byp_rd), .i_es_byp_data (es_byp_data),
    .i_ms_byp_rd (ms_byp_rd), .i_ms_byp_data (ms_byp_data),
    .i_ws_byp_rd (ws_byp_rd), .i_ws_byp_data (ws_byp_data),
    .i_ws_rf_wen (ws_rf_wen), .i_ws_rf_waddr (ws_rf_waddr), .i_ws_rf_wdata (ws_rf_wdata),
    .o_ds_allowin (ds_allowin), .o_ds_to_es_valid (ds_to_es_valid),
    .o_es_pc (es_pc), .o_es_rs1_data (rs1_data), .o_es_rs2_data (rs2_data),
    .o_es_imm (es_imm), .o_es_rd (es_rd), .o_es_alu_op (es_alu_op),
    .o_es_src_a (es_src_a), .o_es_src_b (es_src_b), .o_es_gpr_wen (gpr_wen),
    .o_es_mem_ren (mem_ren), .o_es_mem_wen (mem_wen), .o_es_mem_op (mem_op),
    .o_es_invalid (es_invalid), .o_br_taken (br_taken), .o_br_stall (br_stall),
    .o_br_target (br_target)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset && ds_to_es_valid && es_allowin) begin
      leave_count <= leave_count + 1;
    end
  end

  stall_excludes_issue: assert property (@(posedge clk) disable iff (reset)
    !(br_stall && (br_taken || ds_to_es_valid)))
    else begin
      $display("branch stall was high together with a taken branch or an issue");
      test_errors++;
    end

  blocked_closes_input: assert property (@(posedge clk) disable iff (reset)
    (ds_to_es_valid && !es_allowin) |-> !ds_allowin)
    else begin
      $display("decode accepted from fetch while full and blocked by execute");
      test_errors++;
    end

  blocked_holds_outputs: assert property (@(posedge clk) disable iff (reset)
    (ds_to_es_valid && !es_allowin) |=>
      ($stable(es_pc) && $stable(es_imm) && $stable(es_rd) && $stable(es_alu_op) &&
       $stable(es_src_a) && $stable(es_src_b) && $stable(gpr_wen) && $stable(mem_ren) &&
       $stable(mem_wen) && $stable(mem_op) && $stable(es_invalid)))
    else begin
      $display("execute outputs changed while execute was not accepting");
      test_errors++;
    end

  function automatic logic [XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [AW-1:0] rand_reg(); // never x0
    return AW'(($unsigned($random(seed)) % 31) + 1);
  endfunction

  function automatic logic [XLEN-1:0] sext(input logic [XLEN-1:0] v, input int bits);
    logic [XLEN-1:0] r;
    r = v;
    for (int i = bits; i < XLEN; i++) r[i] = v[bits-1];
    return r;
  endfunction

  function automatic logic [ILEN-1:0] enc_r(input logic [2:0] f3, input logic [AW-1:0] rd_f,
                                            input logic [AW-1:0] rs1, input logic [AW-1:0] rs2);
    return {7'b0, rs2, rs1, f3, rd_f, rv_isa_pkg::OP};
  endfunction

  function automatic logic [ILEN-1:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                            input logic [AW-1:0] rd_f, input logic [AW-1:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, f3, rd_f, opc};
  endfunction

  function automatic logic [ILEN-1:0] enc_s(input logic [2:0] f3, input logic [AW-1:0] rs1,
                                            input logic [AW-1:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::STORE};
  endfunction

  function automatic logic [ILEN-1:0] enc_b(input logic [2:0] f3, input logic [AW-1:0] rs1,
                                            input logic [AW-1:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::BRANCH};
  endfunction

  function automatic logic [ILEN-1:0] enc_j(input logic [AW-1:0] rd_f, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd_f, rv_isa_pkg::JAL};
  endfunction

  // rv64i branch conditions
  function automatic logic branch_expect(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b);
    case (f3)
      rv_isa_pkg::F3_BEQ:  return a == b;
      rv_isa_pkg::F3_BNE:  return a != b;
      rv_isa_pkg::F3_BLT:  return $signed(a) < $signed(b);
      rv_isa_pkg::F3_BGE:  return $signed(a) >= $signed(b);
      rv_isa_pkg::F3_BLTU: return a < b;
      rv_isa_pkg::F3_BGEU: return a >= b;
      default:             return 1'b0;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check(input string name, input logic [XLEN-1:0] expected,
                       input logic [XLEN-1:0] actual);
    value_match: assert (actual === expected)
      else begin
        $display("Fail %s expected %0h actual %0h", name, expected, actual);
        test_errors++;
      end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
      pass_tests++;
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      fail_tests++;
    end
    test_errors = 0;
  endtask

  // hands one instruction to decode, returns mid-cycle with it held
  task automatic issue(input logic [ILEN-1:0] inst, input logic [XLEN-1:0] inst_pc);
    int  waited;
    logic took;
    next_cycle();
    waited   = 0;
    took     = 1'b0;
    fs_valid = 1'b1;
    fs_inst  = inst;
    fs_pc    = inst_pc;
    while (!took) begin
      #1;
      took = ds_allowin;
      next_cycle();
      waited++;
      if (!took && (waited >= WAIT_LIMIT)) begin
        $display("timeout: decode never accepted instruction %h", inst);
        $display("TESTBENCH FAILED");
        $finish;
      end
    end
    fs_valid = 1'b0;
    #10;
  endtask

  initial begin
    br_funcs = '{rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE, rv_isa_pkg::F3_BLT,
                 rv_isa_pkg::F3_BGE, rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU};
    reset = 1'b1;
    fs_valid = 1'b0;
    fs_inst = '0;
    fs_pc = '0;
    es_allowin = 1'b1;
    es_load = 1'b0;
    es_byp_rd = '0;
    es_byp_data = '0;
    ms_byp_rd = '0;
    ms_byp_data = '0;
    ws_byp_rd = '0;
    ws_byp_data = '0;
    ws_rf_wen = 1'b0;
    ws_rf_waddr = '0;
    ws_rf_wdata = '0;
    shadow[0] = '0;
    repeat (4) @(posedge clk);
    #2 reset = 1'b0;
    #10;
    check("reset allowin", 1, ds_allowin);
    check("reset valid", 0, ds_to_es_valid);
    check("reset br_taken", 0, br_taken);
    check("reset br_stall", 0, br_stall);
    end_test("reset");

    // fill every register, x0 write must be dropped
    for (int r = 0; r < 32; r++) begin
      da = rand64();
      ws_rf_wen = 1'b1;
      ws_rf_waddr = AW'(r);
      ws_rf_wdata = da;
      if (r != 0) shadow[r] = da;
      next_cycle();
    end
    ws_rf_wen = 1'b0;
    for (int n = 0; n < 8; n++) begin
      ra = rand_reg();
      rb = (n == 0) ? '0 : rand_reg();
      issue(enc_r(3'b000, 5'd7, ra, rb), rand64());
      check("regfile rs1", shadow[ra], rs1_data);
      check("regfile rs2", shadow[rb], rs2_data);
    end
    end_test("register read");

    ra = rand_reg();
    rb = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
    issue(enc_r(3'b000, 5'd3, ra, rb), rand64());
    es_allowin = 1'b0; // keep the add parked while the sources change
    da = rand64();
    db = rand64();
    dc = rand64();
    next_cycle();
    es_byp_rd = ra;
    es_byp_data = da;
    ms_byp_rd = ra;
    ms_byp_data = db;
    ws_byp_rd = ra;
    ws_byp_data = dc;
    #10;
    check("fwd es over ms", da, rs1_data);
    check("fwd untouched rs2", shadow[rb], rs2_data);
    next_cycle();
    es_byp_rd = '0;
    #10;
    check("fwd ms over ws", db, rs1_data);
    next_cycle();
    ms_byp_rd = '0;
    #10;
    check("fwd ws only", dc, rs1_data);
    next_cycle();
    ws_byp_rd = '0;
    #10;
    check("fwd none", shadow[ra], rs1_data);
    next_cycle();
    es_allowin = 1'b1;
    ms_byp_rd = rb;
    ws_byp_rd = rb;
    issue(enc_r(3'b000, 5'd3, 5'd0, rb), rand64());
    check("fwd x0 stays zero", 0, rs1_data);
    check("fwd ms over ws rs2", db, rs2_data);
    next_cycle();
    ms_byp_rd = '0;
    ws_byp_rd = '0;
    end_test("forwarding");

    ra = rand_reg();
    es_load = 1'b1;
    es_byp_rd = ra;
    es_byp_data = '0;
    boff = {12'(rand64()), 1'b0};
    pc = rand64();
    issue(enc_b(rv_isa_pkg::F3_BEQ, ra, 5'd0, boff), pc);
    for (int n = 0; n < 3; n++) begin
      check("stall valid", 0, ds_to_es_valid);
      check("stall allowin", 0, ds_allowin);
      check("stall br_stall", 1, br_stall);
      check("stall br_taken", 0, br_taken);
      next_cycle();
      #10;
    end
    next_cycle();
    es_load = 1'b0;
    #10;
    check("release valid", 1, ds_to_es_valid);
    check("release br_stall", 0, br_stall);
    check("release br_taken", 1, br_taken);
    check("release target", pc + sext(XLEN'(boff), 13), br_target);
    next_cycle();
    es_byp_rd = '0;
    end_test("load-use stall");

    es_allowin = 1'b0;
    imm12 = 12'(rand64());
    pc = rand64();
    issue(enc_i(rv_isa_pkg::OP_IMM, 3'b000, 5'd9, rand_reg(), imm12), pc);
    pc_b = rand64();
    next_cycle();
    leaves_before = leave_count;
    fs_valid = 1'b1; // second instruction waits at the door
    fs_inst = enc_r(3'b000, 5'd4, rand_reg(), rand_reg());
    fs_pc = pc_b;
    for (int n = 0; n < 3; n++) begin
      #10;
      check("blocked allowin", 0, ds_allowin);
      check("blocked valid", 1, ds_to_es_valid);
      check("blocked pc", pc, es_pc);
      check("blocked imm", sext(XLEN'(imm12), 12), es_imm);
      next_cycle();
    end
    es_allowin = 1'b1;
    #10;
    check("reopen allowin", 1, ds_allowin);
    next_cycle();
    es_allowin = 1'b0;
    fs_valid = 1'b0;
    #10;
    check("one leaves", 1, leave_count - leaves_before);
    check("next held pc", pc_b, es_pc);
    next_cycle();
    es_allowin = 1'b1;
    next_cycle();
    end_test("back-pressure");

    for (int f = 0; f < 6; f++) begin
      for (int t = 0; t < 3; t++) begin
        ra = rand_reg();
        rb = (t == 1) ? ra : rand_reg();
        boff = {12'(rand64()), 1'b0};
        pc = rand64();
        exp_taken = branch_expect(br_funcs[f], shadow[ra], shadow[rb]);
        issue(enc_b(br_funcs[f], ra, rb, boff), pc);
        check($sformatf("branch f3=%0d taken", br_funcs[f]), exp_taken, br_taken);
        if (exp_taken) begin
          check("branch target", pc + sext(XLEN'(boff), 13), br_target);
        end
      end
    end
    joff = {20'(rand64()), 1'b0};
    pc = rand64();
    issue(enc_j(5'd1, joff), pc);
    check("jal taken", 1, br_taken);
    check("jal target", pc + sext(XLEN'(joff), 21), br_target);
    check("jal rd", 1, es_rd);
    check("jal gpr_wen", 1, gpr_wen);
    check("jal src_a", id_bus_pkg::PC, es_src_a);
    ra = rand_reg();
    imm12 = 12'(rand64());
    issue(enc_i(rv_isa_pkg::JALR, 3'b000, 5'd1, ra, imm12), rand64());
    check("jalr taken", 1, br_taken);
    check("jalr target", (shadow[ra] + sext(XLEN'(imm12), 12)) & ~XLEN'(1), br_target);
    end_test("branch and jump");

    rd = rand_reg();
    imm12 = 12'(rand64());
    issue(enc_i(rv_isa_pkg::OP_IMM, 3'b000, rd, rand_reg(), imm12), rand64());
    check("addi imm", sext(XLEN'(imm12), 12), es_imm);
    check("addi rd", rd, es_rd);
    check("addi alu", id_bus_pkg::ADD, es_alu_op);
    check("addi src_a", id_bus_pkg::RS1, es_src_a);
    check("addi src_b", id_bus_pkg::IMM, es_src_b);
    check("addi gpr_wen", 1, gpr_wen);
    check("addi mem", 0, {mem_ren, mem_wen});
    imm20 = 20'(rand64());
    issue({imm20, rd, rv_isa_pkg::LUI}, rand64());
    check("lui imm", sext(XLEN'({imm20, 12'b0}), 32), es_imm);
    check("lui alu", id_bus_pkg::PASS_B, es_alu_op);
    check("lui gpr_wen", 1, gpr_wen);
    issue(enc_i(rv_isa_pkg::LOAD, 3'b011, rd, rand_reg(), imm12), rand64());
    check("ld imm", sext(XLEN'(imm12), 12), es_imm);
    check("ld mem_ren", 1, mem_ren);
    check("ld mem_op", 3, mem_op);
    check("ld gpr_wen", 1, gpr_wen);
    issue(enc_s(3'b011, rand_reg(), rand_reg(), imm12), rand64());
    check("sd imm", sext(XLEN'(imm12), 12), es_imm);
    check("sd mem_wen", 1, mem_wen);
    check("sd gpr_wen", 0, gpr_wen);
    issue({25'(rand64()), 7'b1111111}, rand64()); // not an rv64i major opcode
    check("unknown invalid", 1, es_invalid);
    check("unknown enables", 0, {gpr_wen, mem_ren, mem_wen});
    check("unknown br_taken", 0, br_taken);
    end_test("decode");

    next_cycle();
    $display("tests passed %0d failed %0d", pass_tests, fail_tests);
    if ((fail_tests == 0) && (test_errors == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
